/* logic/game_mem_pkg.sv */
package game_mem_pkg;

    ////////////////////////////////////////
    // Bus geometry
    ////////////////////////////////////////

    localparam int DATA_W     = 18;
    localparam int ADDR_W     = 14;
    localparam int VID_ADDR_W = 11;

    // Plain bus and main RAM word
    typedef logic [DATA_W-1:0] data_word_t;

    // One video RAM cell
    typedef struct packed {
        logic [5:0] glyph;
        logic [5:0] fg;
        logic [5:0] bg;
    } tile_t;

    ////////////////////////////////////////
    // Address map
    ////////////////////////////////////////

    // Video window covers 2048 words from here
    localparam logic [ADDR_W-1:0] VID_BASE = 14'h3000;

    // Gun status registers
    localparam logic [ADDR_W-1:0] P1_SHOT_ADDR = 14'd254;
    localparam logic [ADDR_W-1:0] P1_HIT_ADDR  = 14'd255;
    localparam logic [ADDR_W-1:0] P2_SHOT_ADDR = 14'd252;
    localparam logic [ADDR_W-1:0] P2_HIT_ADDR  = 14'd253;

    // Where a port B access lands
    typedef enum logic [1:0] {
        REG_MAIN  = 2'd0,
        REG_VIDEO = 2'd1,
        REG_GUN1  = 2'd2,
        REG_GUN2  = 2'd3
    } bus_region_t;

endpackage

/* logic/mem_port_if.sv */
`timescale 1ns/10ps

// One synchronous RAM port
interface mem_port_if #(
    parameter type word_t = game_mem_pkg::data_word_t,
    parameter int  AW     = game_mem_pkg::ADDR_W
);

    logic          wr;
    logic [AW-1:0] addr;
    word_t         din;
    word_t         dout;

    // Side that issues accesses
    modport ctrl (
        output wr,
        output addr,
        output din,
        input  dout
    );

    // Memory side
    modport ram (
        input  wr,
        input  addr,
        input  din,
        output dout
    );

endinterface

/* logic/dual_port_ram.sv */
`timescale 1ns/10ps

module dual_port_ram #(
    parameter type word_t = game_mem_pkg::data_word_t,
    parameter int  AW     = game_mem_pkg::ADDR_W
) (
    input logic     a_clk,
    mem_port_if.ram port_a,
    mem_port_if.ram port_b
);

    localparam int DEPTH = 2 ** AW;

    // Contents undefined until written
    word_t mem [0:DEPTH-1];

    ////////////////////////////////////////
    // Both ports on one clock
    ////////////////////////////////////////

    always_ff @(posedge a_clk) begin
        // Port A is write-first
        if (port_a.wr) begin
            mem[port_a.addr] <= port_a.din;
            port_a.dout      <= port_a.din;
        end else begin
            port_a.dout <= mem[port_a.addr];
        end

        // Port B is write-first
        // On a same-address collision port B wins
        if (port_b.wr) begin
            mem[port_b.addr] <= port_b.din;
            port_b.dout      <= port_b.din;
        end else begin
            port_b.dout <= mem[port_b.addr];
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Two writers on one word in the same cycle leave it ambiguous
    no_write_collision: assert property (
        @(posedge a_clk)
        !(port_a.wr && port_b.wr && (port_a.addr == port_b.addr))
    ) else begin
        $error("dual_port_ram: both ports write address %h", port_a.addr);
    end

endmodule

/* logic/gun_channel.sv */
`timescale 1ns/10ps

module gun_channel #(
    parameter int HIT_WINDOW = 16
) (
    input  logic a_clk,
    input  logic reset,
    input  logic trigger,
    input  logic sens,
    input  logic clear_shot,
    input  logic clear_hit,
    output logic shot,
    output logic hit,
    output logic shot_flag,
    output logic hit_flag
);

    localparam int CNT_W = $clog2(HIT_WINDOW + 1);

    logic                  trig_s1;
    logic                  trig_s2;
    logic                  trig_d;
    logic                  sens_s1;
    logic                  sens_s2;
    logic                  trig_rise;
    logic                  win_open;
    logic                  hit_taken;
    logic [CNT_W-1:0]      win_cnt;
    logic [HIT_WINDOW-1:0] shot_hist;

    ////////////////////////////////////////
    // Input synchronisers
    ////////////////////////////////////////

    always_ff @(posedge a_clk) begin
        if (reset) begin
            trig_s1 <= 1'b0;
            trig_s2 <= 1'b0;
            sens_s1 <= 1'b0;
            sens_s2 <= 1'b0;
        end else begin
            trig_s1 <= trigger;
            trig_s2 <= trig_s1;
            sens_s1 <= sens;
            sens_s2 <= sens_s1;
        end
    end

    assign trig_rise = trig_s2 && !trig_d;
    assign win_open  = (win_cnt != '0);

    // Edge register so a held trigger fires once
    always_ff @(posedge a_clk) begin
        if (reset) begin
            trig_d <= 1'b0;
            shot   <= 1'b0;
        end else begin
            trig_d <= trig_s2;
            shot   <= trig_rise;
        end
    end

    ////////////////////////////////////////
    // Hit window and hit pulse
    ////////////////////////////////////////

    // Loaded with the shot pulse and reloaded by a new edge
    always_ff @(posedge a_clk) begin
        if (reset) begin
            win_cnt <= '0;
        end else if (trig_rise) begin
            win_cnt <= CNT_W'(HIT_WINDOW);
        end else if (win_open) begin
            win_cnt <= win_cnt - 1'b1;
        end
    end

    // One hit per shot
    always_ff @(posedge a_clk) begin
        if (reset) begin
            hit       <= 1'b0;
            hit_taken <= 1'b0;
        end else begin
            hit <= sens_s2 && win_open && !hit_taken;
            if (trig_rise) begin
                hit_taken <= 1'b0;
            end else if (sens_s2 && win_open) begin
                hit_taken <= 1'b1;
            end
        end
    end

    // A new event beats a clear in the same cycle
    always_ff @(posedge a_clk) begin
        if (reset) begin
            shot_flag <= 1'b0;
            hit_flag  <= 1'b0;
        end else begin
            if (shot) begin
                shot_flag <= 1'b1;
            end else if (clear_shot) begin
                shot_flag <= 1'b0;
            end
            if (hit) begin
                hit_flag <= 1'b1;
            end else if (clear_hit) begin
                hit_flag <= 1'b0;
            end
        end
    end

    // Shots seen over the last HIT_WINDOW cycles
    always_ff @(posedge a_clk) begin
        if (reset) begin
            shot_hist <= '0;
        end else begin
            shot_hist <= HIT_WINDOW'({shot_hist, shot});
        end
    end

    // A hit needs a shot pulse within the last HIT_WINDOW cycles
    hit_in_window: assert property (
        @(posedge a_clk) disable iff (reset)
        hit |-> (shot_hist != '0)
    ) else begin
        $error("gun_channel: hit outside the window");
    end

    shot_single_cycle: assert property (
        @(posedge a_clk) disable iff (reset)
        shot |=> !shot
    ) else begin
        $error("gun_channel: shot held for two cycles");
    end

endmodule

/* logic/memory_map.sv */
`timescale 1ns/10ps

module memory_map #(
    parameter int HIT_WINDOW = 16
) (
    input  logic                                a_clk,
    input  logic                                reset,

    // Light guns
    input  logic                                p1_trigger,
    input  logic                                p1_sens,
    input  logic                                p2_trigger,
    input  logic                                p2_sens,
    output logic                                p1_shot,
    output logic                                p1_hit,
    output logic                                p2_shot,
    output logic                                p2_hit,

    // Port A for CPU fetch
    input  logic                                a_wr,
    input  logic [game_mem_pkg::ADDR_W-1:0]     a_addr,
    input  game_mem_pkg::data_word_t            a_din,
    output game_mem_pkg::data_word_t            a_dout,

    // Port B for the CPU data bus
    input  logic                                b_wr,
    input  logic [game_mem_pkg::ADDR_W-1:0]     b_addr,
    input  game_mem_pkg::data_word_t            b_din,
    output game_mem_pkg::data_word_t            b_dout,

    // Video scanout
    input  logic [game_mem_pkg::VID_ADDR_W-1:0] vid_addr,
    output game_mem_pkg::tile_t                 vid_pixel
);

    import game_mem_pkg::*;

    bus_region_t           b_region;
    bus_region_t           b_region_q;
    logic                  gun_flag;
    logic                  gun_flag_q;
    logic [VID_ADDR_W-1:0] vid_offset;

    logic                  p1_shot_flag;
    logic                  p1_hit_flag;
    logic                  p2_shot_flag;
    logic                  p2_hit_flag;
    logic                  p1_clear_shot;
    logic                  p1_clear_hit;
    logic                  p2_clear_shot;
    logic                  p2_clear_hit;

    mem_port_if #(.word_t(data_word_t), .AW(ADDR_W))     main_a ();
    mem_port_if #(.word_t(data_word_t), .AW(ADDR_W))     main_b ();
    mem_port_if #(.word_t(tile_t),      .AW(VID_ADDR_W)) vid_scan ();
    mem_port_if #(.word_t(tile_t),      .AW(VID_ADDR_W)) vid_bus ();

    ////////////////////////////////////////
    // Port B address decode
    ////////////////////////////////////////

    always_comb begin
        if (b_addr == P1_SHOT_ADDR || b_addr == P1_HIT_ADDR) begin
            b_region = REG_GUN1;
        end else if (b_addr == P2_SHOT_ADDR || b_addr == P2_HIT_ADDR) begin
            b_region = REG_GUN2;
        end else if (b_addr[ADDR_W-1:VID_ADDR_W] == VID_BASE[ADDR_W-1:VID_ADDR_W]) begin
            b_region = REG_VIDEO;
        end else begin
            b_region = REG_MAIN;
        end
    end

    // Window offset into video RAM
    assign vid_offset = VID_ADDR_W'(b_addr - VID_BASE);

    // Flag behind the addressed gun register
    always_comb begin
        case (b_addr)
            P1_SHOT_ADDR: gun_flag = p1_shot_flag;
            P1_HIT_ADDR:  gun_flag = p1_hit_flag;
            P2_SHOT_ADDR: gun_flag = p2_shot_flag;
            P2_HIT_ADDR:  gun_flag = p2_hit_flag;
            default:      gun_flag = 1'b0;
        endcase
    end

    // Register writes double as clear strobes
    assign p1_clear_shot = b_wr && (b_addr == P1_SHOT_ADDR);
    assign p1_clear_hit  = b_wr && (b_addr == P1_HIT_ADDR);
    assign p2_clear_shot = b_wr && (b_addr == P2_SHOT_ADDR);
    assign p2_clear_hit  = b_wr && (b_addr == P2_HIT_ADDR);

    ////////////////////////////////////////
    // RAM port hookup
    ////////////////////////////////////////

    assign main_a.wr   = a_wr;
    assign main_a.addr = a_addr;
    assign main_a.din  = a_din;
    assign a_dout      = main_a.dout;

    assign main_b.wr   = b_wr && (b_region == REG_MAIN);
    assign main_b.addr = b_addr;
    assign main_b.din  = b_din;

    assign vid_bus.wr   = b_wr && (b_region == REG_VIDEO);
    assign vid_bus.addr = vid_offset;
    assign vid_bus.din  = tile_t'(b_din);

    // Scanout only reads
    assign vid_scan.wr   = 1'b0;
    assign vid_scan.addr = vid_addr;
    assign vid_scan.din  = '0;
    assign vid_pixel     = vid_scan.dout;

    dual_port_ram #(.word_t(data_word_t), .AW(ADDR_W)) u_main_ram (
        .a_clk  (a_clk),
        .port_a (main_a.ram),
        .port_b (main_b.ram)
    );

    dual_port_ram #(.word_t(tile_t), .AW(VID_ADDR_W)) u_vid_ram (
        .a_clk  (a_clk),
        .port_a (vid_scan.ram),
        .port_b (vid_bus.ram)
    );

    ////////////////////////////////////////
    // Light-gun channels
    ////////////////////////////////////////

    gun_channel #(.HIT_WINDOW(HIT_WINDOW)) u_gun_p1 (
        .a_clk      (a_clk),
        .reset      (reset),
        .trigger    (p1_trigger),
        .sens       (p1_sens),
        .clear_shot (p1_clear_shot),
        .clear_hit  (p1_clear_hit),
        .shot       (p1_shot),
        .hit        (p1_hit),
        .shot_flag  (p1_shot_flag),
        .hit_flag   (p1_hit_flag)
    );

    gun_channel #(.HIT_WINDOW(HIT_WINDOW)) u_gun_p2 (
        .a_clk      (a_clk),
        .reset      (reset),
        .trigger    (p2_trigger),
        .sens       (p2_sens),
        .clear_shot (p2_clear_shot),
        .clear_hit  (p2_clear_hit),
        .shot       (p2_shot),
        .hit        (p2_hit),
        .shot_flag  (p2_shot_flag),
        .hit_flag   (p2_hit_flag)
    );

    ////////////////////////////////////////
    // Port B read path
    ////////////////////////////////////////

    // Aligns region and flag with the RAM read latency
    always_ff @(posedge a_clk) begin
        if (reset) begin
            b_region_q <= REG_MAIN;
            gun_flag_q <= 1'b0;
        end else begin
            b_region_q <= b_region;
            gun_flag_q <= gun_flag;
        end
    end

    always_comb begin
        case (b_region_q)
            REG_MAIN:  b_dout = main_b.dout;
            REG_VIDEO: b_dout = data_word_t'(vid_bus.dout);
            default:   b_dout = {{(DATA_W-1){1'b0}}, gun_flag_q};
        endcase
    end

    b_wr_known: assert property (
        @(posedge a_clk) disable iff (reset)
        !$isunknown(b_wr)
    ) else begin
        $error("memory_map: b_wr is unknown");
    end

endmodule

/* tb/memory_map_checker.sv */
`timescale 1ns/10ps

module memory_map_checker (
    input  logic                            a_clk,
    input  logic [63:0]                     rec,
    input  game_mem_pkg::data_word_t        a_dout,
    input  game_mem_pkg::data_word_t        b_dout,
    input  logic [game_mem_pkg::DATA_W-1:0] vid_pixel,
    input  logic                            p1_shot,
    input  logic                            p1_hit,
    input  logic                            p2_shot,
    input  logic                            p2_hit,
    output int                              checks,
    output int                              errors
);

    localparam logic [3:0] OP_A_WR   = 4'h1;
    localparam logic [3:0] OP_A_RD   = 4'h2;
    localparam logic [3:0] OP_B_RD   = 4'h4;
    localparam logic [3:0] OP_VID_RD = 4'h5;
    localparam logic [3:0] OP_PULSES = 4'h7;

    logic [63:0] pending = '0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          n_p1_shot = 0;
    int          n_p1_hit = 0;
    int          n_p2_shot = 0;
    int          n_p2_hit = 0;

    assign checks = n_checks;
    assign errors = n_errors;

    task automatic compare(input string name, input logic [19:0] got, input logic [19:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL test %0d: %s = 0x%05h, expected 0x%05h", n_checks, name, got, exp);
        end else begin
            $display("ok   test %0d: %s = 0x%05h", n_checks, name, got);
        end
    endtask

    ////////////////////////////////////////
    // Read results and pulse counts
    ////////////////////////////////////////

    always @(posedge a_clk) begin
        // Output for the access presented one cycle earlier
        case (pending[63:60])
            OP_A_WR, OP_A_RD: compare("a_dout", 20'(a_dout), pending[19:0]);
            OP_B_RD:          compare("b_dout", 20'(b_dout), pending[19:0]);
            OP_VID_RD:        compare("vid_pixel", 20'(vid_pixel), pending[19:0]);
            default: begin
            end
        endcase
        pending <= rec;

        n_p1_shot += int'(p1_shot === 1'b1);
        n_p1_hit  += int'(p1_hit === 1'b1);
        n_p2_shot += int'(p2_shot === 1'b1);
        n_p2_hit  += int'(p2_hit === 1'b1);

        // Group of records ends here with one count per nibble
        if (rec[63:60] == OP_PULSES) begin
            compare("p1_shot pulses", 20'(n_p1_shot), 20'(rec[15:12]));
            compare("p1_hit pulses", 20'(n_p1_hit), 20'(rec[11:8]));
            compare("p2_shot pulses", 20'(n_p2_shot), 20'(rec[7:4]));
            compare("p2_hit pulses", 20'(n_p2_hit), 20'(rec[3:0]));
            n_p1_shot = 0;
            n_p1_hit  = 0;
            n_p2_shot = 0;
            n_p2_hit  = 0;
        end
    end

endmodule

/* tb/tb_memory_map.sv */
`timescale 1ns/10ps

module tb_memory_map;

    import game_mem_pkg::*;

    localparam int HIT_WINDOW = 16;
    localparam int MAX_RECS   = 256;
    localparam int RESET_CYC  = 8;

    // Record opcodes from the first column of the data file
    localparam logic [3:0] OP_IDLE   = 4'h0;
    localparam logic [3:0] OP_A_WR   = 4'h1;
    localparam logic [3:0] OP_A_RD   = 4'h2;
    localparam logic [3:0] OP_B_WR   = 4'h3;
    localparam logic [3:0] OP_B_RD   = 4'h4;
    localparam logic [3:0] OP_VID_RD = 4'h5;
    localparam logic [3:0] OP_RESET  = 4'h6;
    localparam logic [3:0] OP_END    = 4'hf;

    logic                  a_clk;
    logic                  reset;
    logic                  p1_trigger;
    logic                  p1_sens;
    logic                  p2_trigger;
    logic                  p2_sens;
    logic                  p1_shot;
    logic                  p1_hit;
    logic                  p2_shot;
    logic                  p2_hit;
    logic                  a_wr;
    logic [ADDR_W-1:0]     a_addr;
    data_word_t            a_din;
    data_word_t            a_dout;
    logic                  b_wr;
    logic [ADDR_W-1:0]     b_addr;
    data_word_t            b_din;
    data_word_t            b_dout;
    logic [VID_ADDR_W-1:0] vid_addr;
    tile_t                 vid_pixel;

    logic [63:0] recs [0:MAX_RECS-1];
    logic [63:0] rec;
    int          n_recs;
    int          n_cycles;
    int          cycle_limit;
    int          cycle_cnt;
    int          checks;
    int          errors;
    integer      seed;

    always #2 a_clk = ~a_clk;

    memory_map #(.HIT_WINDOW(HIT_WINDOW)) DUT (.*);

    memory_map_checker check_unit (.*);

    // Idle records hold for the count in their address column
    function automatic int record_cycles(input logic [63:0] r);
        if (r[63:60] == OP_IDLE && r[59:44] > 16'd1) begin
            return int'(r[59:44]);
        end
        return 1;
    endfunction

    task automatic load_records();
        for (int i = 0; i < MAX_RECS; i++) begin
            recs[i] = {OP_END, 60'(i)};
        end
        $readmemh("tb/memory_map_testdata.hex", recs);
        n_recs   = 0;
        n_cycles = 0;
        while (n_recs < MAX_RECS && recs[n_recs][63:60] != OP_END) begin
            n_cycles += record_cycles(recs[n_recs]);
            n_recs++;
        end
    endtask

    task automatic apply_record(input logic [63:0] r);
        rec   <= r;
        reset <= (r[63:60] == OP_RESET);
        a_wr  <= (r[63:60] == OP_A_WR);
        b_wr  <= (r[63:60] == OP_B_WR);
        {p1_trigger, p1_sens, p2_trigger, p2_sens} <= r[23:20];
        case (r[63:60])
            OP_A_WR, OP_A_RD: begin
                a_addr <= r[57:44];
                a_din  <= r[41:24];
            end
            OP_B_WR, OP_B_RD: begin
                b_addr <= r[57:44];
                b_din  <= r[41:24];
            end
            OP_VID_RD: begin
                vid_addr <= r[54:44];
            end
            default: begin
                // Random filler on data buses with no strobe
                a_din <= data_word_t'($random(seed));
                b_din <= data_word_t'($random(seed));
            end
        endcase
    endtask

    initial begin
        seed       = 17;
        a_clk      = 1'b0;
        reset      = 1'b1;
        p1_trigger = 1'b0;
        p1_sens    = 1'b0;
        p2_trigger = 1'b0;
        p2_sens    = 1'b0;
        a_wr       = 1'b0;
        a_addr     = '0;
        a_din      = '0;
        b_wr       = 1'b0;
        b_addr     = '0;
        b_din      = '0;
        vid_addr   = '0;
        rec        = '0;
        cycle_cnt  = 0;
        load_records();
        cycle_limit = 4 * (n_cycles + RESET_CYC) + 100;

        repeat (RESET_CYC) @(posedge a_clk);
        reset <= 1'b0;
        for (int i = 0; i < n_recs; i++) begin
            repeat (record_cycles(recs[i])) begin
                @(posedge a_clk);
                apply_record(recs[i]);
            end
        end

        // Drain the read pipeline
        repeat (3) begin
            @(posedge a_clk);
            apply_record('0);
        end
        @(negedge a_clk);

        $display("Totals: %0d checks, %0d failed", checks, errors);
        if (checks == 0) begin
            $display("No checks ran, the data file gave no read or pulse records");
        end
        if (errors == 0 && checks > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    ////////////////////////////////////////
    // Run length guard
    ////////////////////////////////////////

    always @(posedge a_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: run still going after %0d cycles", cycle_cnt);
            $display("Verification failed");
            $finish;
        end
    end

endmodule

/* verilog.f */
logic/game_mem_pkg.sv
logic/mem_port_if.sv
logic/dual_port_ram.sv
logic/gun_channel.sv
logic/memory_map.sv
tb/memory_map_checker.sv
tb/tb_memory_map.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the memory_map testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_memory_map \
    --Mdir "$BUILD" -o sim_memory_map
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD/sim_memory_map" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Result lines printed by the testbench top
if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
exit 0

/* tb/memory_map_testdata.hex */
// Columns op_addr_data_guns_expect. Ops 0 idle (addr is a repeat count), 1 A write,
// 2 A read, 3 B write, 4 B read, 5 video read, 6 reset, 7 pulse counts, f end.
// Guns nibble is p1 trigger, p1 sens, p2 trigger, p2 sens; op 7 expects p1s_p1h_p2s_p2h.
1_0010_2abcd_0_2abcd
2_0010_00000_0_2abcd
3_0123_1f00f_0_00000
2_0123_00000_0_1f00f
1_0456_0babe_0_0babe
4_0456_00000_0_0babe
3_3010_15a5a_0_00000
5_0010_00000_0_15a5a
4_3010_00000_0_15a5a
2_0010_00000_0_2abcd
4_00fe_00000_0_00000
0_0006_00000_8_00000
0_0006_00000_8_00000
7_0000_00000_8_01000
4_00fe_00000_8_00001
4_00fc_00000_8_00000
3_00fe_00000_8_00000
4_00fe_00000_0_00000
0_0004_00000_0_00000
0_0003_00000_8_00000
0_0002_00000_c_00000
0_0014_00000_0_00000
7_0000_00000_0_01100
4_00ff_00000_0_00001
0_0003_00000_8_00000
0_0018_00000_0_00000
0_0003_00000_4_00000
0_0004_00000_0_00000
7_0000_00000_0_01000
3_00ff_00000_0_00000
4_00ff_00000_0_00000
0_0003_00000_2_00000
0_0002_00000_3_00000
0_0014_00000_0_00000
7_0000_00000_0_00011
4_00fc_00000_0_00001
4_00fd_00000_0_00001
4_00fe_00000_0_00001
4_00ff_00000_0_00000
6_0000_00000_0_00000
4_00fc_00000_0_00000
4_00fd_00000_0_00000
4_00fe_00000_0_00000
4_00ff_00000_0_00000
2_0010_00000_0_2abcd
0_0004_00000_5_00000
0_0006_00000_0_00000
7_0000_00000_0_00000
0_0003_00000_a_00000
0_0006_00000_0_00000
7_0000_00000_0_01010
f_0000_00000_0_00000
